/* tests/stack_cpu_tests.txt */
# test NAME, prog ADDR COUNT WORD..., mem ADDR COUNT VALUE..., end closes a test
# expect COUNT then one DATA_ADDR VALUE pair per store in order; counts decimal, rest hex
test push_i_pop
prog 00 7 0923 1810 0FFF 1811 0805 1BFF 7006
expect 3 010 0123 011 07FF 3FF 0005
end
test push_copy
prog 00 5 0020 1830 0021 1831 7004
mem 020 2 BEEF 1234
expect 2 030 BEEF 031 1234
end
test alu_arith
prog 00 8 0041 0040 2000 1850 0041 0040 2800 1851
prog 08 9 0040 0041 2800 1852 0043 0042 2000 1853 7010
mem 040 4 1234 0F0F FFFF 0002
expect 4 050 2143 051 0325 052 FCDB 053 0001
end
test alu_logic
prog 00 8 0061 0060 4000 1870 0061 0060 5000 1871
prog 08 9 0061 0060 5800 1872 0061 0060 6800 1873 7010
mem 060 2 F0F0 3C3C
expect 4 070 3030 071 FCFC 072 CCCC 073 0F0F
end
test goto_skip
prog 00 8 0811 1880 7005 08BA 1881 0822 1882 7007
expect 2 080 0011 082 0022
end
test if_eq
prog 00 7 0800 7805 08A1 1890 7007 08B1 1890
prog 07 7 0805 780C 08A2 1891 700E 08B2 1891
prog 0E 10 0803 0801 2800 7815 08A3 1892 7017 08B3 1892 7017
expect 3 090 00B1 091 00A2 092 00A3
end
test if_lt
prog 00 9 0803 0801 2800 8807 08A1 18A0 7009 08B1 18A0
prog 09 7 0FFF 880E 08A2 18A1 7010 08B2 18A1
prog 10 8 0800 8815 08A3 18A2 7017 08B3 18A2 7017
expect 3 0A0 00B1 0A1 00A2 0A2 00A3
end
test call_nested
prog 00 6 0801 18B0 A008 0804 18B0 7005
prog 08 6 0802 18B1 A010 0803 18B1 A800
prog 10 3 08AA 18B2 A800
expect 5 0B0 0001 0B1 0002 0B2 00AA 0B1 0003 0B0 0004
end

/* files.f */
design/stack_cpu_pkg.sv
design/alu.sv
design/lifo_stack.sv
design/program_counter.sv
design/sequencer.sv
design/stack_cpu.sv
tests/stack_cpu_tb.sv

/* tests/stack_cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_cpu_tb;

    import stack_cpu_pkg::*;

    localparam int IMEM_DEPTH = 2 ** PC_WIDTH;
    localparam int DMEM_DEPTH = 2 ** DATA_ADDR_WIDTH;

    logic       clk;
    logic       reset;
    pc_t        inst_addr;
    logic       inst_read;
    word_t      instruction;
    data_addr_t data_addr;
    logic       data_read;
    logic       data_write;
    word_t      data_out;
    word_t      data_in;

    word_t imem [IMEM_DEPTH];
    word_t dmem [DMEM_DEPTH];

    // Stores seen on the bus in arrival order
    data_addr_t store_addr [$];
    word_t      store_data [$];

    // Current test
    string      test_name;
    int         prog_words;
    data_addr_t exp_addr [$];
    word_t      exp_data [$];

    int fd;
    int pass_count;
    int fail_count;
    int test_errors;

    stack_cpu UUT (
        .clk         (clk),
        .reset       (reset),
        .inst_addr   (inst_addr),
        .inst_read   (inst_read),
        .instruction (instruction),
        .data_addr   (data_addr),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_out    (data_out),
        .data_in     (data_in)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Memories answer one cycle after the strobe
    always @(posedge clk) begin
        if (inst_read) begin
            instruction <= imem[inst_addr];
        end
        if (data_read) begin
            data_in <= dmem[data_addr];
        end
        if (data_write && !reset) begin
            dmem[data_addr] = data_out;
            store_addr.push_back(data_addr);
            store_data.push_back(data_out);
        end
    end

    task automatic fill_memories();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            // GOTO to its own address
            imem[i] = 16'h7000 | word_t'(i);
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = 16'hD000 ^ word_t'(i);
        end
    endtask

    task automatic read_test(output bit found);
        string kw;
        string rest;
        bit    done;
        int    addr;
        int    count;
        int    value;
        int    code;
        found = 1'b0;
        done = 1'b0;
        prog_words = 0;
        exp_addr.delete();
        exp_data.delete();
        while (!done && $fscanf(fd, "%s", kw) == 1) begin
            if (kw.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (kw == "test") begin
                code = $fscanf(fd, "%s", test_name);
                found = 1'b1;
            end else if (kw == "prog") begin
                code = $fscanf(fd, "%h %d", addr, count);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", value);
                    imem[addr + i] = word_t'(value);
                end
                prog_words += count;
            end else if (kw == "mem") begin
                code = $fscanf(fd, "%h %d", addr, count);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", value);
                    dmem[addr + i] = word_t'(value);
                end
            end else if (kw == "expect") begin
                code = $fscanf(fd, "%d", count);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    exp_addr.push_back(data_addr_t'(addr));
                    exp_data.push_back(word_t'(value));
                end
            end else if (kw == "end") begin
                done = 1'b1;
            end else begin
                $display("Unknown keyword %s in the test file", kw);
                fail_count++;
            end
        end
    endtask

    task automatic check_store(input int n, input data_addr_t addr, input word_t data);
        assert (addr == exp_addr[n] && data == exp_data[n]) else begin
            $display("** Error %s: store %0d expected [%03h] = %04h, actual [%03h] = %04h",
                     test_name, n, exp_addr[n], exp_data[n], addr, data);
            test_errors++;
        end
    endtask

    task automatic run_test();
        int         cycles;
        int         limit;
        int         checked;
        data_addr_t got_addr;
        word_t      got_data;
        cycles = 0;
        checked = 0;
        test_errors = 0;
        limit = 40 * prog_words + 100;
        while (checked < exp_addr.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            while (store_addr.size() > 0 && checked < exp_addr.size()) begin
                got_addr = store_addr.pop_front();
                got_data = store_data.pop_front();
                check_store(checked, got_addr, got_data);
                checked++;
            end
        end
        assert (checked == exp_addr.size()) else begin
            $display("%s: stores did not arrive in time, %0d of %0d seen in %0d cycles",
                     test_name, checked, exp_addr.size(), cycles);
            test_errors++;
        end
        // Program should now sit in its final loop
        repeat (20) @(negedge clk);
        assert (store_addr.size() == 0) else begin
            $display("%s: %0d store(s) happened after the last expected one",
                     test_name, store_addr.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed, %0d stores checked", test_name, checked);
        end else begin
            fail_count++;
            $display("%s: failed with %0d error(s)", test_name, test_errors);
        end
    endtask

    initial begin
        bit found;
        reset = 1'b1;
        instruction = '0;
        data_in = '0;
        pass_count = 0;
        fail_count = 0;
        fd = $fopen("tests/stack_cpu_tests.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open tests/stack_cpu_tests.txt");
            fail_count++;
        end
        found = (fd != 0);
        while (found) begin
            @(posedge clk);
            reset <= 1'b1;
            fill_memories();
            read_test(found);
            if (found) begin
                repeat (3) @(posedge clk);
                store_addr.delete();
                store_data.delete();
                reset <= 1'b0;
                run_test();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (pass_count + fail_count > 0) else begin
            $display("No tests were found in the test file");
            fail_count++;
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/stack_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_cpu (
    input  logic                      clk,
    input  logic                      reset,
    output stack_cpu_pkg::pc_t        inst_addr,
    output logic                      inst_read,
    input  stack_cpu_pkg::word_t      instruction,
    output stack_cpu_pkg::data_addr_t data_addr,
    output logic                      data_read,
    output logic                      data_write,
    output stack_cpu_pkg::word_t      data_out,
    input  stack_cpu_pkg::word_t      data_in
);

    import stack_cpu_pkg::*;

    logic    os_push;
    logic    os_pop;
    word_t   os_push_data;
    word_t   os_top;
    logic    rs_push;
    logic    rs_pop;
    pc_t     rs_top;
    opcode_e alu_op;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    pc_sel_e pc_sel;
    pc_t     target;
    pc_t     link_pc;

    sequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .inst_read    (inst_read),
        .instruction  (instruction),
        .data_addr    (data_addr),
        .data_read    (data_read),
        .data_write   (data_write),
        .data_out     (data_out),
        .data_in      (data_in),
        .os_push      (os_push),
        .os_pop       (os_pop),
        .os_push_data (os_push_data),
        .os_top       (os_top),
        .rs_push      (rs_push),
        .rs_pop       (rs_pop),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .pc_sel       (pc_sel),
        .target       (target)
    );

    alu alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    // Working values
    lifo_stack #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (OPERAND_STACK_DEPTH)
    ) operand_stack (
        .clk       (clk),
        .reset     (reset),
        .push      (os_push),
        .pop       (os_pop),
        .push_data (os_push_data),
        .top       (os_top),
        .full      (),
        .empty     ()
    );

    // Subroutine return addresses
    lifo_stack #(
        .WIDTH (PC_WIDTH),
        .DEPTH (RETURN_STACK_DEPTH)
    ) return_stack (
        .clk       (clk),
        .reset     (reset),
        .push      (rs_push),
        .pop       (rs_pop),
        .push_data (link_pc),
        .top       (rs_top),
        .full      (),
        .empty     ()
    );

    program_counter program_counter (
        .clk        (clk),
        .reset      (reset),
        .pc_sel     (pc_sel),
        .target     (target),
        .test_value (os_top),
        .return_pc  (rs_top),
        .pc         (inst_addr),
        .link_pc    (link_pc)
    );

endmodule

`default_nettype wire

/* design/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   inst_read,
    input  stack_cpu_pkg::word_t   instruction,
    output stack_cpu_pkg::data_addr_t data_addr,
    output logic                   data_read,
    output logic                   data_write,
    output stack_cpu_pkg::word_t   data_out,
    input  stack_cpu_pkg::word_t   data_in,
    output logic                   os_push,
    output logic                   os_pop,
    output stack_cpu_pkg::word_t   os_push_data,
    input  stack_cpu_pkg::word_t   os_top,
    output logic                   rs_push,
    output logic                   rs_pop,
    output stack_cpu_pkg::opcode_e alu_op,
    output stack_cpu_pkg::word_t   alu_a,
    output stack_cpu_pkg::word_t   alu_b,
    input  stack_cpu_pkg::word_t   alu_result,
    output stack_cpu_pkg::pc_sel_e pc_sel,
    output stack_cpu_pkg::pc_t     target
);

    import stack_cpu_pkg::*;

    typedef enum logic [4:0] {
        IDLE,
        FETCH,
        WAIT_INST,
        DECODE,
        PUSH_IMM,
        STORE,
        JUMP,
        BRANCH,
        MEM_READ,
        MEM_PUSH,
        POP_A,
        POP_B,
        ALU_EXEC,
        ALU_PUSH,
        CALL_LINK,
        CALL_JUMP,
        RET_LOAD,
        RET_POP,
        INCREMENT
    } state_e;

    state_e   state;
    state_e   next_state;
    word_t    inst_reg;
    opcode_e  opcode;
    operand_t operand;
    word_t    a_reg;
    word_t    b_reg;
    word_t    result_reg;

    // Instruction fields
    assign opcode  = opcode_e'(inst_reg[DATA_WIDTH-1:OPERAND_WIDTH]);
    assign operand = inst_reg[OPERAND_WIDTH-1:0];

    assign data_addr = operand[DATA_ADDR_WIDTH-1:0];
    assign target    = operand[PC_WIDTH-1:0];
    assign data_out  = os_top;
    assign alu_op    = opcode;
    assign alu_a     = a_reg;
    assign alu_b     = b_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Held instruction and ALU operands
    always_ff @(posedge clk) begin
        if (state == WAIT_INST) begin
            inst_reg <= instruction;
        end
        if (state == POP_A) begin
            a_reg <= os_top;
        end
        if (state == POP_B) begin
            b_reg <= os_top;
        end
        if (state == ALU_EXEC) begin
            result_reg <= alu_result;
        end
    end

    always_comb begin
        next_state   = state;
        inst_read    = 1'b0;
        data_read    = 1'b0;
        data_write   = 1'b0;
        os_push      = 1'b0;
        os_pop       = 1'b0;
        os_push_data = result_reg;
        rs_push      = 1'b0;
        rs_pop       = 1'b0;
        pc_sel       = PC_HOLD;
        case (state)
            IDLE: begin
                next_state = FETCH;
            end
            FETCH: begin
                inst_read  = 1'b1;
                next_state = WAIT_INST;
            end
            WAIT_INST: begin
                next_state = DECODE;
            end
            DECODE: begin
                case (opcode)
                    PUSH:                          next_state = MEM_READ;
                    PUSH_I:                        next_state = PUSH_IMM;
                    POP:                           next_state = STORE;
                    ADD, SUB, AND, OR, XOR, NOT:   next_state = POP_A;
                    GOTO:                          next_state = JUMP;
                    IF_EQ, IF_LT:                  next_state = BRANCH;
                    CALL:                          next_state = CALL_LINK;
                    RET:                           next_state = RET_LOAD;
                    // Unknown opcodes fall through as a no-op
                    default:                       next_state = INCREMENT;
                endcase
            end
            PUSH_IMM: begin
                os_push      = 1'b1;
                os_push_data = {{(DATA_WIDTH-OPERAND_WIDTH){1'b0}}, operand};
                next_state   = INCREMENT;
            end
            STORE: begin
                os_pop     = 1'b1;
                data_write = 1'b1;
                next_state = INCREMENT;
            end
            JUMP: begin
                pc_sel     = PC_JUMP;
                next_state = FETCH;
            end
            BRANCH: begin
                // Program counter tests the popped top this cycle
                os_pop     = 1'b1;
                pc_sel     = (opcode == IF_EQ) ? PC_BRANCH_EQ : PC_BRANCH_LT;
                next_state = FETCH;
            end
            MEM_READ: begin
                data_read  = 1'b1;
                next_state = MEM_PUSH;
            end
            MEM_PUSH: begin
                os_push      = 1'b1;
                os_push_data = data_in;
                next_state   = INCREMENT;
            end
            POP_A: begin
                os_pop     = 1'b1;
                next_state = POP_B;
            end
            POP_B: begin
                os_pop     = 1'b1;
                next_state = ALU_EXEC;
            end
            ALU_EXEC: begin
                next_state = ALU_PUSH;
            end
            ALU_PUSH: begin
                os_push    = 1'b1;
                next_state = INCREMENT;
            end
            CALL_LINK: begin
                // link_pc is still the address after the CALL
                rs_push    = 1'b1;
                next_state = CALL_JUMP;
            end
            CALL_JUMP: begin
                pc_sel     = PC_JUMP;
                next_state = FETCH;
            end
            RET_LOAD: begin
                pc_sel     = PC_RETURN;
                next_state = RET_POP;
            end
            RET_POP: begin
                rs_pop     = 1'b1;
                next_state = FETCH;
            end
            INCREMENT: begin
                pc_sel     = PC_INC;
                next_state = FETCH;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    single_fetch_strobe: assert property (
        @(posedge clk) disable iff (reset) inst_read |=> !inst_read
    ) else $error("sequencer: inst_read high on consecutive cycles");

    data_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(data_read && data_write)
    ) else $error("sequencer: data_read and data_write together");

endmodule

`default_nettype wire

/* design/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  stack_cpu_pkg::pc_sel_e pc_sel,
    input  stack_cpu_pkg::pc_t     target,
    input  stack_cpu_pkg::word_t   test_value,
    input  stack_cpu_pkg::pc_t     return_pc,
    output stack_cpu_pkg::pc_t     pc,
    output stack_cpu_pkg::pc_t     link_pc
);

    import stack_cpu_pkg::*;

    pc_t pc_next;

    // Also the return address pushed by CALL
    assign link_pc = pc + 1'b1;

    always_comb begin
        case (pc_sel)
            PC_INC: begin
                pc_next = link_pc;
            end
            PC_JUMP: begin
                pc_next = target;
            end
            PC_BRANCH_EQ: begin
                pc_next = (test_value == '0) ? target : link_pc;
            end
            PC_BRANCH_LT: begin
                // Sign bit set means negative
                pc_next = test_value[DATA_WIDTH-1] ? target : link_pc;
            end
            PC_RETURN: begin
                pc_next = return_pc;
            end
            default: begin
                pc_next = pc;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_sel != PC_HOLD) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* design/lifo_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module lifo_stack #(
    parameter int WIDTH = stack_cpu_pkg::DATA_WIDTH,
    parameter int DEPTH = stack_cpu_pkg::OPERAND_STACK_DEPTH
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] push_data,
    output logic [WIDTH-1:0] top,
    output logic             full,
    output logic             empty
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH+1)-1:0] count;
    logic [$clog2(DEPTH)-1:0]   top_index;

    // count holds the entries in use and the top sits at count-1
    assign top_index = count[$clog2(DEPTH)-1:0] - 1'b1;
    assign empty     = (count == '0);
    assign full      = (count == DEPTH);

    // Empty stack reads as zero
    assign top = empty ? '0 : mem[top_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push && pop && !empty) begin
            count <= count;
        end else if (push && !full) begin
            count <= count + 1'b1;
        end else if (pop && !empty) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && pop && !empty) begin
            // Replace top in place
            mem[top_index] <= push_data;
        end else if (push && !full) begin
            mem[count[$clog2(DEPTH)-1:0]] <= push_data;
        end
    end

    push_while_full: assert property (
        @(posedge clk) disable iff (reset) push && !pop |-> !full
    ) else $error("lifo_stack: push while full is dropped");

    pop_while_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("lifo_stack: pop while empty is dropped");

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  stack_cpu_pkg::opcode_e op,
    input  stack_cpu_pkg::word_t   a,
    input  stack_cpu_pkg::word_t   b,
    output stack_cpu_pkg::word_t   result
);

    import stack_cpu_pkg::*;

    // a is the value that was on top of the stack
    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            NOT: begin
                // Unary and ignores b
                result = ~a;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/stack_cpu_pkg.sv */
`default_nettype none

package stack_cpu_pkg;

    // Word and field widths
    localparam int DATA_WIDTH      = 16;
    localparam int PC_WIDTH        = 5;
    localparam int DATA_ADDR_WIDTH = 10;
    localparam int OPCODE_WIDTH    = 5;
    localparam int OPERAND_WIDTH   = 11;

    // Stack depths
    localparam int OPERAND_STACK_DEPTH = 16;
    localparam int RETURN_STACK_DEPTH  = 8;

    typedef logic [DATA_WIDTH-1:0]      word_t;
    typedef logic [PC_WIDTH-1:0]        pc_t;
    typedef logic [DATA_ADDR_WIDTH-1:0] data_addr_t;
    typedef logic [OPERAND_WIDTH-1:0]   operand_t;

    // Opcode numbering has gaps at unused codes
    typedef enum logic [OPCODE_WIDTH-1:0] {
        PUSH   = 5'd0,
        PUSH_I = 5'd1,
        POP    = 5'd3,
        ADD    = 5'd4,
        SUB    = 5'd5,
        AND    = 5'd8,
        OR     = 5'd10,
        XOR    = 5'd11,
        NOT    = 5'd13,
        GOTO   = 5'd14,
        IF_EQ  = 5'd15,
        IF_LT  = 5'd17,
        CALL   = 5'd20,
        RET    = 5'd21
    } opcode_e;

    // Next program counter source
    typedef enum logic [2:0] {
        PC_HOLD,
        PC_INC,
        PC_JUMP,
        PC_BRANCH_EQ,
        PC_BRANCH_LT,
        PC_RETURN
    } pc_sel_e;

endpackage

`default_nettype wire
